//--- hdl/sa_macros.svh
`ifndef SA_MACROS_SVH
`define SA_MACROS_SVH

// array geometry
`define SA_ROWS 4
`define SA_COLS 4

// data widths
`define SA_IW 8   // signed operand
`define SA_OW 24  // accumulator, holds 31 full-scale products
`define SA_KW 5   // job length field

// cycles for the last wavefront to cross the grid
`define SA_FLUSH (`SA_ROWS + `SA_COLS - 1)

`endif

//--- hdl/sa_data_pkg.sv
`include "sa_macros.svh"

package sa_data_pkg;

    // one signed operand
    typedef logic signed [`SA_IW-1:0] elem_t;

    // one signed accumulator
    typedef logic signed [`SA_OW-1:0] acc_t;

    // one column of A, lane r feeds row r
    typedef elem_t [`SA_ROWS-1:0] a_vec_t;

    // one row of B, lane c feeds column c
    typedef elem_t [`SA_COLS-1:0] b_vec_t;

    // one row of C as it leaves row 0
    typedef acc_t [`SA_COLS-1:0] res_vec_t;

    // job length K, also reused for every phase count
    typedef logic [`SA_KW-1:0] klen_t;

endpackage

//--- hdl/sa_ctrl_pkg.sv
`include "sa_macros.svh"

package sa_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FEED  = 2'd1,  // operands enter
        FLUSH = 2'd2,  // skewed wavefronts drain through the grid
        DRAIN = 2'd3   // accumulators shift out through row 0
    } seq_state_e;

    // travels right with the A operands
    typedef struct packed {
        logic mac_en;     // valid operand pair present
        logic acc_first;  // pair starts a new sum
    } pe_ctrl_t;

    // sequencer to datapath
    typedef struct packed {
        logic feed;   // aligned with the operand cycles
        logic first;  // first operand cycle of a job
        logic drain;  // shift accumulators up
    } phase_t;

endpackage

//--- hdl/sa_pe.sv
`timescale 1ns/1ns

module sa_pe (
    input  logic                 clk,
    input  logic                 rst_i,
    input  sa_data_pkg::elem_t   a_i,
    input  sa_data_pkg::elem_t   b_i,
    input  sa_ctrl_pkg::pe_ctrl_t ctrl_i,
    input  logic                 drain_i,
    input  sa_data_pkg::acc_t    acc_i,   // from the element below
    output sa_data_pkg::elem_t   a_o,
    output sa_data_pkg::elem_t   b_o,
    output sa_ctrl_pkg::pe_ctrl_t ctrl_o,
    output sa_data_pkg::acc_t    acc_o
);

    sa_data_pkg::elem_t    a_q;
    sa_data_pkg::elem_t    b_q;
    sa_ctrl_pkg::pe_ctrl_t ctrl_q;
    sa_data_pkg::acc_t     acc_q;
    sa_data_pkg::acc_t     prod;

    assign prod = a_i * b_i;  // both signed, sign-extended to accumulator width

    always_ff @(posedge clk) begin
        if (rst_i) begin
            a_q    <= '0;
            b_q    <= '0;
            ctrl_q <= '0;
            acc_q  <= '0;
        end else begin
            a_q    <= a_i;
            b_q    <= b_i;
            ctrl_q <= ctrl_i;
            if (drain_i) begin
                acc_q <= acc_i;  // shift up one row
            end else if (ctrl_i.mac_en) begin
                if (ctrl_i.acc_first) begin
                    acc_q <= prod;  // drop the previous job's sum
                end else begin
                    acc_q <= acc_q + prod;
                end
            end
        end
    end

    assign a_o    = a_q;
    assign b_o    = b_q;
    assign ctrl_o = ctrl_q;
    assign acc_o  = acc_q;

endmodule

//--- hdl/sa_array.sv
`timescale 1ns/1ns
`include "sa_macros.svh"

module sa_array (
    input  logic                                     clk,
    input  logic                                     rst_i,
    input  sa_data_pkg::a_vec_t                      a_i,
    input  sa_ctrl_pkg::pe_ctrl_t [`SA_ROWS-1:0]     ctrl_i,
    input  sa_data_pkg::b_vec_t                      b_i,
    input  logic                                     drain_i,
    output sa_data_pkg::res_vec_t                    res_o
);

    // index 0 is the entry edge, the last index the far edge
    sa_data_pkg::elem_t    a_x    [`SA_ROWS-1:0][`SA_COLS:0];
    sa_ctrl_pkg::pe_ctrl_t ctrl_x [`SA_ROWS-1:0][`SA_COLS:0];
    sa_data_pkg::elem_t    b_x    [`SA_COLS-1:0][`SA_ROWS:0];

    // accumulators move upward, row 0 is the exit
    sa_data_pkg::acc_t     acc_x  [`SA_COLS-1:0][`SA_ROWS:0];

    genvar h, w;

    generate
        for (h = 0; h < `SA_ROWS; h++) begin : g_row_in
            assign a_x[h][0]    = a_i[h];
            assign ctrl_x[h][0] = ctrl_i[h];
        end

        for (w = 0; w < `SA_COLS; w++) begin : g_col_io
            assign b_x[w][0]          = b_i[w];
            assign acc_x[w][`SA_ROWS] = '0;  // bottom edge shifts in zero
            assign res_o[w]           = acc_x[w][0];
        end
    endgenerate

    generate
        for (h = 0; h < `SA_ROWS; h++) begin : g_row
            for (w = 0; w < `SA_COLS; w++) begin : g_col
                sa_pe u_pe (
                    .clk     (clk),
                    .rst_i   (rst_i),
                    .a_i     (a_x[h][w]),
                    .b_i     (b_x[w][h]),
                    .ctrl_i  (ctrl_x[h][w]),
                    .drain_i (drain_i),
                    .acc_i   (acc_x[w][h+1]),
                    .a_o     (a_x[h][w+1]),
                    .b_o     (b_x[w][h+1]),
                    .ctrl_o  (ctrl_x[h][w+1]),
                    .acc_o   (acc_x[w][h])
                );
            end
        end
    endgenerate

endmodule

//--- hdl/sa_skew.sv
`timescale 1ns/1ns
`include "sa_macros.svh"

module sa_skew (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  sa_ctrl_pkg::phase_t                  phase_i,
    input  sa_data_pkg::a_vec_t                  a_i,
    input  sa_data_pkg::b_vec_t                  b_i,
    output sa_data_pkg::a_vec_t                  a_o,
    output sa_ctrl_pkg::pe_ctrl_t [`SA_ROWS-1:0] ctrl_o,
    output sa_data_pkg::b_vec_t                  b_o
);

    sa_ctrl_pkg::pe_ctrl_t ctrl_in;

    assign ctrl_in.mac_en    = phase_i.feed;
    assign ctrl_in.acc_first = phase_i.first;

    assign a_o[0]    = a_i[0];  // lane 0 needs no delay
    assign ctrl_o[0] = ctrl_in;
    assign b_o[0]    = b_i[0];

    for (genvar r = 1; r < `SA_ROWS; r++) begin : g_a_lane
        sa_data_pkg::elem_t    [r-1:0] a_sr;
        sa_ctrl_pkg::pe_ctrl_t [r-1:0] c_sr;

        always_ff @(posedge clk) begin
            a_sr[0] <= a_i[r];
            for (int i = 1; i < r; i++) begin
                a_sr[i] <= a_sr[i-1];
            end
        end

        always_ff @(posedge clk) begin
            if (rst_i) begin
                c_sr <= '0;
            end else begin
                c_sr[0] <= ctrl_in;
                for (int i = 1; i < r; i++) begin
                    c_sr[i] <= c_sr[i-1];
                end
            end
        end

        assign a_o[r]    = a_sr[r-1];
        assign ctrl_o[r] = c_sr[r-1];
    end

    for (genvar c = 1; c < `SA_COLS; c++) begin : g_b_lane
        sa_data_pkg::elem_t [c-1:0] b_sr;

        always_ff @(posedge clk) begin
            b_sr[0] <= b_i[c];
            for (int i = 1; i < c; i++) begin
                b_sr[i] <= b_sr[i-1];
            end
        end

        assign b_o[c] = b_sr[c-1];
    end

endmodule

//--- hdl/sa_count.sv
`timescale 1ns/1ns

module sa_count (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               load_i,
    input  sa_data_pkg::klen_t value_i,
    output logic               zero_o
);

    sa_data_pkg::klen_t cnt_q;

    // holds at zero until the next load
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= value_i;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign zero_o = (cnt_q == '0);

endmodule

//--- hdl/sa_seq.sv
`timescale 1ns/1ns
`include "sa_macros.svh"

module sa_seq (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                start_i,
    input  sa_data_pkg::klen_t  k_len_i,
    input  logic                cnt_zero_i,
    output logic                cnt_load_o,
    output sa_data_pkg::klen_t  cnt_value_o,
    output sa_ctrl_pkg::phase_t phase_o,
    output logic                busy_o,
    output logic                feed_o,
    output logic                res_valid_o,
    output logic                done_o
);

    sa_ctrl_pkg::seq_state_e state_q;
    sa_ctrl_pkg::seq_state_e state_d;
    logic                    feed_q;   // host operands trail feed_o by one cycle
    logic                    first_q;
    logic                    accept;

    assign accept = start_i && (k_len_i != '0);  // zero length is dropped

    always_comb begin
        state_d     = state_q;
        cnt_load_o  = 1'b0;
        cnt_value_o = '0;
        case (state_q)
            sa_ctrl_pkg::IDLE: if (accept) begin
                state_d     = sa_ctrl_pkg::FEED;
                cnt_load_o  = 1'b1;
                cnt_value_o = k_len_i - 1'b1;
            end
            sa_ctrl_pkg::FEED: if (cnt_zero_i) begin
                state_d     = sa_ctrl_pkg::FLUSH;
                cnt_load_o  = 1'b1;
                cnt_value_o = sa_data_pkg::klen_t'(`SA_FLUSH - 1);
            end
            sa_ctrl_pkg::FLUSH: if (cnt_zero_i) begin
                state_d     = sa_ctrl_pkg::DRAIN;
                cnt_load_o  = 1'b1;
                cnt_value_o = sa_data_pkg::klen_t'(`SA_ROWS - 1);
            end
            sa_ctrl_pkg::DRAIN: if (cnt_zero_i) begin
                state_d = sa_ctrl_pkg::IDLE;
            end
            default: state_d = sa_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= sa_ctrl_pkg::IDLE;
            feed_q  <= 1'b0;
            first_q <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            feed_q  <= feed_o;
            first_q <= feed_o && !feed_q;  // rising edge of feed
            done_o  <= (state_q == sa_ctrl_pkg::DRAIN) && cnt_zero_i;
        end
    end

    assign busy_o      = (state_q != sa_ctrl_pkg::IDLE);
    assign feed_o      = (state_q == sa_ctrl_pkg::FEED);
    assign res_valid_o = (state_q == sa_ctrl_pkg::DRAIN);

    // drain straight from the state so row 0 shows in the first DRAIN cycle
    assign phase_o.feed  = feed_q;
    assign phase_o.first = first_q;
    assign phase_o.drain = res_valid_o;

endmodule

//--- hdl/sa_top.sv
`timescale 1ns/1ns
`include "sa_macros.svh"

module sa_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  sa_data_pkg::klen_t    k_len_i,
    input  sa_data_pkg::a_vec_t   a_col_i,
    input  sa_data_pkg::b_vec_t   b_row_i,
    output logic                  feed_o,
    output logic                  busy_o,
    output logic                  res_valid_o,
    output logic                  done_o,
    output sa_data_pkg::res_vec_t res_row_o
);

    logic                                cnt_load;
    sa_data_pkg::klen_t                  cnt_value;
    logic                                cnt_zero;
    sa_ctrl_pkg::phase_t                 phase;
    sa_data_pkg::a_vec_t                 a_skew;
    sa_ctrl_pkg::pe_ctrl_t [`SA_ROWS-1:0] ctrl_skew;
    sa_data_pkg::b_vec_t                 b_skew;

    sa_seq u_seq (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .k_len_i     (k_len_i),
        .cnt_zero_i  (cnt_zero),
        .cnt_load_o  (cnt_load),
        .cnt_value_o (cnt_value),
        .phase_o     (phase),
        .busy_o      (busy_o),
        .feed_o      (feed_o),
        .res_valid_o (res_valid_o),
        .done_o      (done_o)
    );

    sa_count u_count (
        .clk     (clk),
        .rst_i   (rst_i),
        .load_i  (cnt_load),
        .value_i (cnt_value),
        .zero_o  (cnt_zero)
    );

    sa_skew u_skew (
        .clk     (clk),
        .rst_i   (rst_i),
        .phase_i (phase),
        .a_i     (a_col_i),
        .b_i     (b_row_i),
        .a_o     (a_skew),
        .ctrl_o  (ctrl_skew),
        .b_o     (b_skew)
    );

    sa_array u_array (
        .clk     (clk),
        .rst_i   (rst_i),
        .a_i     (a_skew),
        .ctrl_i  (ctrl_skew),
        .b_i     (b_skew),
        .drain_i (phase.drain),
        .res_o   (res_row_o)
    );

endmodule

//--- tests/sa_clk_gen.sv
`timescale 1ns/1ns

module sa_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- tests/sa_asserts.sv
`timescale 1ns/1ns

module sa_asserts (
    input logic clk,
    input logic rst_i,
    input logic feed_i,
    input logic busy_i,
    input logic valid_i,
    input logic done_i
);

    int fail_cnt = 0;  // read by the testbench at the end of the run

    a_no_overlap: assert property (@(posedge clk) disable iff (rst_i) !(valid_i && feed_i))
        else begin
            fail_cnt++;
            $error("res_valid_o and feed_o are high in the same cycle");
        end

    a_feed_busy: assert property (@(posedge clk) disable iff (rst_i) feed_i |-> busy_i)
        else begin
            fail_cnt++;
            $error("feed_o is high while busy_o is low");
        end

    a_done_short: assert property (@(posedge clk) disable iff (rst_i) done_i |=> !done_i)
        else begin
            fail_cnt++;
            $error("done_o stays high for more than one cycle");
        end

    // done comes right after the last result row
    a_done_after: assert property (@(posedge clk) disable iff (rst_i)
        done_i |-> !valid_i && $past(valid_i))
        else begin
            fail_cnt++;
            $error("done_o does not follow the fall of res_valid_o");
        end

    a_reset_low: assert property (@(posedge clk)
        rst_i |=> !(feed_i || busy_i || valid_i || done_i))
        else begin
            fail_cnt++;
            $error("status outputs are not low after reset");
        end

endmodule

bind sa_top sa_asserts u_asserts (
    .clk     (clk),
    .rst_i   (rst_i),
    .feed_i  (feed_o),
    .busy_i  (busy_o),
    .valid_i (res_valid_o),
    .done_i  (done_o)
);

//--- tests/sa_tb.sv
`timescale 1ns/1ns
`include "sa_macros.svh"

module sa_tb;

    localparam int KMAX     = 31;
    localparam int N_JOBS   = 9;
    localparam int JOB_CYC  = KMAX + `SA_FLUSH + `SA_ROWS + 12;  // start, gaps and idle checks
    localparam int WDOG_CYC = N_JOBS * JOB_CYC + 100;

    logic                  clk;
    logic                  rst_i;
    logic                  start_i;
    sa_data_pkg::klen_t    k_len_i;
    sa_data_pkg::a_vec_t   a_col_i;
    sa_data_pkg::b_vec_t   b_row_i;
    logic                  feed_o;
    logic                  busy_o;
    logic                  res_valid_o;
    logic                  done_o;
    sa_data_pkg::res_vec_t res_row_o;

    sa_data_pkg::elem_t    a_mat   [`SA_ROWS][KMAX];
    sa_data_pkg::elem_t    b_mat   [KMAX][`SA_COLS];
    longint                exp_mat [`SA_ROWS][`SA_COLS];
    sa_data_pkg::res_vec_t res_q   [$];
    logic [31:0]           lfsr_q;
    int                    errors;
    int                    cyc;
    int                    feed_cycles;
    int                    feed_rise;
    int                    valid_rise;
    int                    done_cnt;
    int                    total;

    sa_clk_gen #(.PERIOD_NS(20)) u_clk (.clk_o(clk));

    sa_top uut (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .k_len_i     (k_len_i),
        .a_col_i     (a_col_i),
        .b_row_i     (b_row_i),
        .feed_o      (feed_o),
        .busy_o      (busy_o),
        .res_valid_o (res_valid_o),
        .done_o      (done_o),
        .res_row_o   (res_row_o)
    );

    // sample status and results mid-cycle
    always @(negedge clk) begin
        cyc++;
        if (!rst_i) begin
            if (feed_o) begin
                if (feed_cycles == 0) feed_rise = cyc;
                feed_cycles++;
            end
            if (res_valid_o) begin
                if (res_q.size() == 0) valid_rise = cyc;
                res_q.push_back(res_row_o);
            end
            if (done_o) done_cnt++;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_elem(output sa_data_pkg::elem_t e);
        for (int i = 0; i < `SA_IW; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            e[i]   = lfsr_q[0];
        end
    endtask

    task automatic check_val(input string name, input longint got, input longint exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic fill_random(input int k_len);
        for (int k = 0; k < k_len; k++) begin
            for (int r = 0; r < `SA_ROWS; r++) rand_elem(a_mat[r][k]);
            for (int c = 0; c < `SA_COLS; c++) rand_elem(b_mat[k][c]);
        end
    endtask

    // full-width reference product
    function automatic void ref_matmul(input int k_len);
        longint sum;
        for (int r = 0; r < `SA_ROWS; r++) begin
            for (int c = 0; c < `SA_COLS; c++) begin
                sum = 0;
                for (int k = 0; k < k_len; k++) begin
                    sum += longint'(a_mat[r][k]) * longint'(b_mat[k][c]);
                end
                exp_mat[r][c] = sum;
            end
        end
    endfunction

    task automatic start_job(input int k_len);
        feed_cycles = 0;
        done_cnt    = 0;
        res_q.delete();
        start_i = 1'b1;
        k_len_i = sa_data_pkg::klen_t'(k_len);
        @(posedge clk);
        #2;
        start_i = 1'b0;
    endtask

    // operand k goes out one cycle after feed_o is seen at an edge
    task automatic feed_ops(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #2;
            for (int r = 0; r < `SA_ROWS; r++) a_col_i[r] = a_mat[r][k];
            for (int c = 0; c < `SA_COLS; c++) b_row_i[c] = b_mat[k][c];
        end
        @(posedge clk);
        #2;
        a_col_i = '0;
        b_row_i = '0;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (done_cnt == 0 && n < limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (done_cnt == 0) begin
            errors++;
            $display("done_o did not pulse within %0d cycles", limit);
        end
    endtask

    task automatic check_job(input int k_len);
        sa_data_pkg::res_vec_t row;
        check_val("feed_o cycles", feed_cycles, k_len);
        check_val("res_valid_o rows", res_q.size(), `SA_ROWS);
        check_val("res_valid_o latency", valid_rise - feed_rise,
                  k_len + `SA_ROWS + `SA_COLS - 1);
        for (int r = 0; r < `SA_ROWS && r < res_q.size(); r++) begin
            row = res_q[r];
            for (int c = 0; c < `SA_COLS; c++) begin
                check_val($sformatf("res_row_o row %0d col %0d", r, c),
                          longint'(row[c]), exp_mat[r][c]);
            end
        end
    endtask

    task automatic run_job(input int k_len, input bit poke);
        start_job(k_len);
        feed_ops(k_len);
        if (poke) begin  // extra start during the flush
            check_val("busy_o at extra start", busy_o, 1);
            start_i = 1'b1;
            @(posedge clk);
            #2;
            start_i = 1'b0;
        end
        wait_done(k_len + `SA_FLUSH + `SA_ROWS + 4);
        check_job(k_len);
    endtask

    task automatic test_identity();
        fill_random(`SA_COLS);
        for (int k = 0; k < `SA_COLS; k++) begin
            for (int c = 0; c < `SA_COLS; c++) b_mat[k][c] = (k == c) ? 8'sd1 : 8'sd0;
        end
        for (int r = 0; r < `SA_ROWS; r++) begin
            for (int c = 0; c < `SA_COLS; c++) exp_mat[r][c] = a_mat[r][c];
        end
        run_job(`SA_COLS, 1'b0);
    endtask

    task automatic test_random();
        int lens [4] = '{1, 3, 7, 31};
        foreach (lens[i]) begin
            fill_random(lens[i]);
            ref_matmul(lens[i]);
            run_job(lens[i], 1'b0);
        end
    endtask

    task automatic test_extremes();
        for (int k = 0; k < KMAX; k++) begin
            for (int r = 0; r < `SA_ROWS; r++) a_mat[r][k] = -8'sd128;
            for (int c = 0; c < `SA_COLS; c++) b_mat[k][c] = -8'sd128;
        end
        for (int r = 0; r < `SA_ROWS; r++) begin
            for (int c = 0; c < `SA_COLS; c++) exp_mat[r][c] = longint'(KMAX) * 16384;
        end
        run_job(KMAX, 1'b0);
    endtask

    task automatic test_ignored_starts();
        done_cnt = 0;
        start_i  = 1'b1;
        k_len_i  = '0;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #2;
            check_val("busy_o after zero-length start", busy_o, 0);
        end
        check_val("done_o count after zero-length start", done_cnt, 0);
        fill_random(7);
        ref_matmul(7);
        run_job(7, 1'b1);
        repeat (4) begin
            @(posedge clk);
            #2;
        end
        check_val("busy_o after job", busy_o, 0);
        check_val("done_o count", done_cnt, 1);
    endtask

    task automatic test_reset_mid_job();
        fill_random(KMAX);
        start_job(KMAX);
        feed_ops(10);
        rst_i = 1'b1;
        @(posedge clk);
        #2;
        check_val("feed_o in reset", feed_o, 0);
        check_val("busy_o in reset", busy_o, 0);
        check_val("res_valid_o in reset", res_valid_o, 0);
        check_val("done_o in reset", done_o, 0);
        for (int c = 0; c < `SA_COLS; c++) begin
            check_val($sformatf("res_row_o col %0d in reset", c), longint'(res_row_o[c]), 0);
        end
        rst_i = 1'b0;
        fill_random(7);
        ref_matmul(7);
        run_job(7, 1'b0);
    endtask

    initial begin
        lfsr_q  = 32'hd73;
        errors  = 0;
        rst_i   = 1'b1;
        start_i = 1'b0;
        k_len_i = '0;
        a_col_i = '0;
        b_row_i = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_i = 1'b0;
        test_identity();
        test_random();
        test_extremes();
        test_ignored_starts();
        test_reset_mid_job();
        repeat (3) @(posedge clk);
        total = errors + uut.u_asserts.fail_cnt;
        $display("errors: %0d from checks, %0d from assertions", errors, uut.u_asserts.fail_cnt);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("run timed out after %0d cycles without finishing the tests", WDOG_CYC);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- sa_mm.f
+incdir+hdl
hdl/sa_data_pkg.sv
hdl/sa_ctrl_pkg.sv
hdl/sa_pe.sv
hdl/sa_array.sv
hdl/sa_skew.sv
hdl/sa_count.sv
hdl/sa_seq.sv
hdl/sa_top.sv
tests/sa_clk_gen.sv
tests/sa_asserts.sv
tests/sa_tb.sv

//--- Bender.yml
package:
  name: sa_mm

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sa_data_pkg.sv
      - hdl/sa_ctrl_pkg.sv
      - hdl/sa_pe.sv
      - hdl/sa_array.sv
      - hdl/sa_skew.sv
      - hdl/sa_count.sv
      - hdl/sa_seq.sv
      - hdl/sa_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/sa_clk_gen.sv
      - tests/sa_asserts.sv
      - tests/sa_tb.sv
